// ==== pit_pkg.sv ====
// channel 0 only, binary counting only; other channels and BCD are not supported
package pit_pkg;

    // bus data width with the control byte in the upper half
    localparam int pit_data_w = 16;

    // width of the count, reload and latch registers
    localparam int pit_count_w = 16;

    // one byte of the bus or of the counter
    localparam int pit_byte_w = 8;

    // bit position of the control byte within a bus word
    localparam int pit_ctrl_lsb = 8;

    // register offsets on bus address bit 1
    localparam logic pit_addr_data = 1'b0;
    localparam logic pit_addr_ctrl = 1'b1;

    // field positions inside the control byte
    localparam int pit_ctrl_chan_lsb = 6;
    localparam int pit_ctrl_rw_lsb = 4;
    localparam int pit_ctrl_mode_lsb = 1;

    // access mode codes of the rw field
    localparam logic [1:0] pit_rw_latch = 2'b00;
    localparam logic [1:0] pit_rw_low = 2'b01;
    localparam logic [1:0] pit_rw_high = 2'b10;
    localparam logic [1:0] pit_rw_both = 2'b11;

    // low two mode bits that select the rate generator (modes 2 and 6)
    localparam logic [1:0] pit_mode_rate_bits = 2'b10;

    // channel field value that addresses counter 0
    localparam logic [1:0] pit_channel0 = 2'b00;

endpackage

// ==== pit_bus_if.sv ====
// strobes are single-cycle pulses valid in the cycle access is sampled; rdata is combinational
`timescale 1ns/1ps

interface pit_bus_if;
    import pit_pkg::*;

    // decoded register accesses
    logic data_wr;
    logic data_rd;
    logic ctrl_wr;

    // raw bus write word from which the channel picks the byte it needs
    logic [pit_data_w-1:0] wdata;

    // read value from the channel with the byte in the low half
    logic [pit_data_w-1:0] rdata;

    modport decoder (
        output data_wr,
        output data_rd,
        output ctrl_wr,
        output wdata,
        input  rdata
    );

    modport channel (
        input  data_wr,
        input  data_rd,
        input  ctrl_wr,
        input  wdata,
        output rdata
    );

endinterface

// ==== pit_tick_sync.sv ====
// pit_clk must stay high and low for at least two clk cycles each, or edges are lost
`timescale 1ns/1ps

module pit_tick_sync (
    input  logic clk,
    input  logic reset,
    input  logic pit_clk,
    output logic tick
);

    logic sync_meta;
    logic sync_level;
    logic level_prev;

    // two stages settle the asynchronous input, the third remembers the last level
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sync_meta <= 1'b0;
            sync_level <= 1'b0;
            level_prev <= 1'b0;
        end else begin
            sync_meta <= pit_clk;
            sync_level <= sync_meta;
            level_prev <= sync_level;
        end
    end

    // one cycle per rising edge of the synchronized level
    assign tick = sync_level & ~level_prev;

endmodule

// ==== pit_bus_decode.sv ====
// master holds access high for one cycle only and must not start a new access while ack is high
`timescale 1ns/1ps

module pit_bus_decode (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          cs,
    input  logic                          access,
    input  logic                          addr,
    input  logic                          wr_en,
    input  logic [1:0]                    bytesel,
    input  logic [pit_pkg::pit_data_w-1:0] data_in,
    output logic [pit_pkg::pit_data_w-1:0] data_out,
    output logic                          ack,
    pit_bus_if.decoder                    bus
);
    import pit_pkg::*;

    logic data_sel;
    logic ctrl_sel;

    // the data register uses the low byte lane, the control register the high lane
    assign data_sel = cs & access & (addr == pit_addr_data) & bytesel[0];
    assign ctrl_sel = cs & access & (addr == pit_addr_ctrl) & bytesel[1];

    assign bus.data_wr = data_sel & wr_en;
    assign bus.data_rd = data_sel & ~wr_en;
    assign bus.ctrl_wr = ctrl_sel & wr_en;
    assign bus.wdata = data_in;

    // every selected access is acknowledged one cycle later, decoded or not
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ack <= 1'b0;
        end else begin
            ack <= cs & access;
        end
    end

    // read data is only presented during the ack cycle of a data read
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            data_out <= '0;
        end else if (bus.data_rd) begin
            data_out <= bus.rdata;
        end else begin
            data_out <= '0;
        end
    end

endmodule

// ==== pit_channel.sv ====
// counter 0 only; counts solely in rate generator modes, holds in all other modes, no gate input
`timescale 1ns/1ps

module pit_channel (
    input  logic        clk,
    input  logic        reset,
    input  logic        tick,
    pit_bus_if.channel  bus,
    output logic        intr
);
    import pit_pkg::*;

    logic [pit_byte_w-1:0]  ctrl_byte;
    logic [1:0]             ctrl_chan;
    logic [1:0]             ctrl_rw;
    logic [2:0]             ctrl_mode;
    logic [pit_byte_w-1:0]  wr_byte;
    logic                   ctrl_ch0_wr;
    logic                   latch_cmd;

    logic [pit_count_w-1:0] count;
    logic [pit_count_w-1:0] reload;
    logic [pit_count_w-1:0] latched_count;
    logic [1:0]             latched;
    logic [1:0]             rw;
    logic [2:0]             mode;
    logic                   byte_low;
    logic [pit_byte_w-1:0]  rd_byte;

    // control word fields
    assign ctrl_byte = bus.wdata[pit_ctrl_lsb +: pit_byte_w];
    assign ctrl_chan = ctrl_byte[pit_ctrl_chan_lsb +: 2];
    assign ctrl_rw = ctrl_byte[pit_ctrl_rw_lsb +: 2];
    assign ctrl_mode = ctrl_byte[pit_ctrl_mode_lsb +: 3];

    // data writes use the low byte lane
    assign wr_byte = bus.wdata[pit_byte_w-1:0];

    // control words for channels 1 and 2 are dropped here
    assign ctrl_ch0_wr = bus.ctrl_wr & (ctrl_chan == pit_channel0);
    assign latch_cmd = ctrl_ch0_wr & (ctrl_rw == pit_rw_latch);

    // programming state, byte pointer and latch flags
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rw <= pit_rw_latch;
            mode <= 3'b000;
            byte_low <= 1'b0;
            latched <= 2'b00;
        end else if (ctrl_ch0_wr) begin
            if (latch_cmd) begin
                // both bytes of the snapshot are pending
                latched <= 2'b11;
            end else begin
                rw <= ctrl_rw;
                mode <= ctrl_mode;
                byte_low <= ctrl_rw[0];
            end
        end else if (bus.data_wr) begin
            // alternate between low and high byte in two-byte mode
            if (rw == pit_rw_both) begin
                byte_low <= ~byte_low;
            end
        end else if (bus.data_rd) begin
            if (|latched) begin
                latched <= {1'b0, latched[1]};
            end
        end
    end

    // snapshot of the count that shifts down one byte per read
    always_ff @(posedge clk) begin
        if (latch_cmd) begin
            latched_count <= count;
        end else if (bus.data_rd && |latched) begin
            latched_count <= {{pit_byte_w{1'b0}}, latched_count[pit_count_w-1:pit_byte_w]};
        end
    end

    // the reload value takes one byte per data write
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            reload <= '0;
        end else if (bus.data_wr) begin
            if (byte_low) begin
                reload[pit_byte_w-1:0] <= wr_byte;
            end else begin
                reload[pit_count_w-1:pit_byte_w] <= wr_byte;
            end
        end
    end

    // the down-counter reloads when it has reached zero
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= '0;
            intr <= 1'b0;
        end else if (tick && mode[1:0] == pit_mode_rate_bits) begin
            count <= ((count == '0) ? reload : count) - 1'b1;
            // intr goes low for one tick period when the terminal count is passed
            intr <= (count != pit_count_w'(1));
        end
    end

    // a pending latch wins over the live count
    always_comb begin
        if (|latched) begin
            rd_byte = latched_count[pit_byte_w-1:0];
        end else if (rw[0]) begin
            rd_byte = count[pit_byte_w-1:0];
        end else begin
            rd_byte = count[pit_count_w-1:pit_byte_w];
        end
    end

    assign bus.rdata = {{(pit_data_w-pit_byte_w){1'b0}}, rd_byte};

endmodule

// ==== pit_timer_top.sv ====
// single-channel interval timer; data register at addr 0 low byte, control at addr 1 high byte
`timescale 1ns/1ps

module pit_timer_top (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          pit_clk,
    input  logic                          cs,
    input  logic                          access,
    input  logic                          addr,
    input  logic [pit_pkg::pit_data_w-1:0] data_in,
    output logic [pit_pkg::pit_data_w-1:0] data_out,
    input  logic [1:0]                    bytesel,
    input  logic                          wr_en,
    output logic                          ack,
    output logic                          intr
);

    logic tick;

    pit_bus_if bus ();

    pit_tick_sync u_tick_sync (
        .clk     (clk),
        .reset   (reset),
        .pit_clk (pit_clk),
        .tick    (tick)
    );

    pit_bus_decode u_bus_decode (
        .clk      (clk),
        .reset    (reset),
        .cs       (cs),
        .access   (access),
        .addr     (addr),
        .wr_en    (wr_en),
        .bytesel  (bytesel),
        .data_in  (data_in),
        .data_out (data_out),
        .ack      (ack),
        .bus      (bus.decoder)
    );

    pit_channel u_channel (
        .clk   (clk),
        .reset (reset),
        .tick  (tick),
        .bus   (bus.channel),
        .intr  (intr)
    );

endmodule

// ==== pit_checker.sv ====
// models counter 0 from the top-level ports; inputs must change away from rising clk edges
`timescale 1ns/1ps

module pit_checker (
    input logic                          clk,
    input logic                          reset,
    input logic                          pit_clk,
    input logic                          cs,
    input logic                          access,
    input logic                          addr,
    input logic                          wr_en,
    input logic [1:0]                    bytesel,
    input logic [pit_pkg::pit_data_w-1:0] data_in,
    input logic [pit_pkg::pit_data_w-1:0] data_out,
    input logic                          ack,
    input logic                          intr,
    input logic [7:0]                    exp_byte,
    input logic                          exp_valid
);
    import pit_pkg::*;

    int mismatch_count = 0;
    int ack_errors = 0;

    logic [2:0]  pit_hist;
    logic [15:0] m_count;
    logic [15:0] m_reload;
    logic [1:0]  m_rw;
    logic [2:0]  m_mode;
    logic        m_low;
    logic        m_intr;
    logic        ack_due;
    logic        read_due;
    logic [7:0]  read_exp;

    // reference state follows the observed bus writes and pit_clk edges
    always @(posedge clk or posedge reset) begin
        if (reset) begin
            pit_hist <= 3'b000;
            m_count <= '0;
            m_reload <= '0;
            m_rw <= 2'b00;
            m_mode <= 3'b000;
            m_low <= 1'b0;
            m_intr <= 1'b0;
            ack_due <= 1'b0;
            read_due <= 1'b0;
            read_exp <= 8'h00;
        end else begin
            pit_hist <= {pit_hist[1:0], pit_clk};
            ack_due <= cs && access;
            read_due <= cs && access && !wr_en && exp_valid;
            read_exp <= exp_byte;
            // the control byte in data_in[15:8] holds channel [15:14], rw [13:12] and mode [11:9]
            if (cs && access && wr_en && addr && bytesel[1] && data_in[15:14] == 2'b00) begin
                if (data_in[13:12] != 2'b00) begin
                    m_rw <= data_in[13:12];
                    m_mode <= data_in[11:9];
                    m_low <= data_in[12];
                end
            end
            if (cs && access && wr_en && !addr && bytesel[0]) begin
                if (m_low) begin
                    m_reload[7:0] <= data_in[7:0];
                end else begin
                    m_reload[15:8] <= data_in[7:0];
                end
                if (m_rw == 2'b11) begin
                    m_low <= !m_low;
                end
            end
            // the count moves at the third clk edge after a pit_clk rise
            if (pit_hist[1] && !pit_hist[2] && m_mode[1:0] == 2'b10) begin
                m_count <= ((m_count == 16'd0) ? m_reload : m_count) - 16'd1;
                m_intr <= (m_count != 16'd1);
            end
        end
    end

    always @(negedge clk) begin
        if (!reset) begin
            if (ack !== ack_due) begin
                ack_errors++;
                if (ack_due) begin
                    $display("%0t: an access was not acknowledged in the following cycle", $time);
                end else begin
                    $display("%0t: ack was raised without an access in the cycle before", $time);
                end
            end
            if (read_due && data_out !== {8'h00, read_exp}) begin
                mismatch_count++;
                $display("Mismatch at %0t: data_out expected %h actual %h",
                         $time, {8'h00, read_exp}, data_out);
            end else if (!read_due && data_out !== '0) begin
                mismatch_count++;
                $display("Mismatch at %0t: data_out expected 0000 actual %h", $time, data_out);
            end
            if (intr !== m_intr) begin
                mismatch_count++;
                $display("Mismatch at %0t: intr expected %b actual %b", $time, m_intr, intr);
            end
        end
    end

endmodule

// ==== tb_pit.sv ====
// runs the operations in pit_vectors.txt; pit_clk only toggles during wait operations
`timescale 1ns/1ps

module tb_pit;
    import pit_pkg::*;

    localparam int max_vectors = 64;
    localparam int half_tick = 4;

    logic                  clk;
    logic                  reset;
    logic                  pit_clk;
    logic                  cs;
    logic                  access;
    logic                  addr;
    logic [pit_data_w-1:0] data_in;
    logic [pit_data_w-1:0] data_out;
    logic [1:0]            bytesel;
    logic                  wr_en;
    logic                  ack;
    logic                  intr;
    logic [7:0]            exp_byte;
    logic                  exp_valid;

    // op, addr, bytesel, data and expected read byte per entry
    logic [35:0] vectors [max_vectors];
    int cycle_count = 0;
    int cycle_limit = 0;
    int bad_vectors = 0;

    pit_timer_top uut (
        .clk(clk), .reset(reset), .pit_clk(pit_clk), .cs(cs), .access(access),
        .addr(addr), .data_in(data_in), .data_out(data_out), .bytesel(bytesel),
        .wr_en(wr_en), .ack(ack), .intr(intr)
    );

    pit_checker chk (
        .clk(clk), .reset(reset), .pit_clk(pit_clk), .cs(cs), .access(access),
        .addr(addr), .wr_en(wr_en), .bytesel(bytesel), .data_in(data_in),
        .data_out(data_out), .ack(ack), .intr(intr), .exp_byte(exp_byte),
        .exp_valid(exp_valid)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("Run stopped after %0d cycles before all vectors were done", cycle_count);
            $display("Test FAILED");
            $finish;
        end
    end

    // drives one access pulse, waits for ack and leaves one idle cycle behind it
    task automatic bus_access(input logic write, input logic a, input logic [1:0] bs,
                              input logic [15:0] d, input logic [7:0] expect_byte);
        @(negedge clk);
        cs = 1'b1;
        access = 1'b1;
        wr_en = write;
        addr = a;
        bytesel = bs;
        data_in = d;
        exp_byte = expect_byte;
        exp_valid = ~write;
        @(negedge clk);
        access = 1'b0;
        exp_valid = 1'b0;
        while (ack !== 1'b1) @(negedge clk);
        @(negedge clk);
        cs = 1'b0;
    endtask

    task automatic run_ticks(input int periods);
        repeat (periods) begin
            @(negedge clk);
            pit_clk = 1'b1;
            repeat (half_tick) @(negedge clk);
            pit_clk = 1'b0;
            repeat (half_tick - 1) @(negedge clk);
        end
    endtask

    initial begin
        int idx;
        logic [3:0] op;
        for (idx = 0; idx < max_vectors; idx++) vectors[idx] = '0;
        $readmemh("pit_vectors.txt", vectors);
        // reset, the operations up to the end marker, the closing wait and a margin
        cycle_limit = 4 + 100;
        idx = 0;
        while (idx < max_vectors && vectors[idx][35:32] != 4'h0) begin
            op = vectors[idx][35:32];
            cycle_limit += (op == 4'h3) ? 2 * half_tick * vectors[idx][23:8] : 3;
            idx++;
        end
        cycle_limit += 3;
        reset = 1'b1;
        pit_clk = 1'b0;
        {cs, access, addr, wr_en, bytesel, data_in, exp_byte, exp_valid} = '0;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        idx = 0;
        while (idx < max_vectors && vectors[idx][35:32] != 4'h0) begin
            op = vectors[idx][35:32];
            case (op)
                4'h1: bus_access(1'b1, vectors[idx][28], vectors[idx][25:24],
                                 vectors[idx][23:8], 8'h00);
                4'h2: bus_access(1'b0, vectors[idx][28], vectors[idx][25:24],
                                 vectors[idx][23:8], vectors[idx][7:0]);
                4'h3: run_ticks(vectors[idx][23:8]);
                default: begin
                    $display("Vector %0d holds an unknown operation %h", idx, op);
                    bad_vectors++;
                end
            endcase
            idx++;
        end
        repeat (3) @(negedge clk);
        $display("Errors: %0d mismatches, %0d ack errors, %0d bad vectors",
                 chk.mismatch_count, chk.ack_errors, bad_vectors);
        if (chk.mismatch_count == 0 && chk.ack_errors == 0 && bad_vectors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== pit_vectors.txt ====
// columns: op_addr_bytesel_data_expected, op 1 write, 2 read, 3 pit_clk periods in data, 0 end
// reads compare the low data_out byte with the last column
2_0_1_0000_00
3_0_0_0003_00
// rate generator, rw 11, reload 5
1_1_2_3400_00
1_0_1_0005_00
1_0_1_0000_00
3_0_0_0001_00
2_0_1_0000_04
3_0_0_0003_00
2_0_1_0000_01
3_0_0_0001_00
2_0_1_0000_00
3_0_0_0001_00
2_0_1_0000_04
// latch at count 4, two ticks pass before the high byte is read
1_1_2_0000_00
2_0_1_0000_04
3_0_0_0002_00
2_0_1_0000_00
2_0_1_0000_02
// low byte only, then high byte only
1_1_2_1400_00
1_0_1_000a_00
3_0_0_0003_00
2_0_1_0000_09
1_1_2_2400_00
1_0_1_0001_00
2_0_1_0000_00
3_0_0_000a_00
2_0_1_0000_01
// control words for channels 1 and 2 must be ignored
1_1_2_5400_00
1_1_2_8000_00
2_0_1_0000_01
3_0_0_0001_00
2_0_1_0000_01
0_0_0_0000_00

// ==== verilog.f ====
pit_pkg.sv
pit_bus_if.sv
pit_tick_sync.sv
pit_bus_decode.sv
pit_channel.sv
pit_timer_top.sv
pit_checker.sv
tb_pit.sv
